// File: source/alu_ops_pkg.sv
package alu_ops_pkg;

    // alu function select, same encoding as the old alu funct field
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0, // a + b
        OP_SUB  = 3'd1, // a - b
        OP_SHL  = 3'd2, // logical left by b
        OP_SHR  = 3'd3, // logical right by b
        OP_LOAD = 3'd4, // pass a
        OP_AND  = 3'd5,
        OP_XOR  = 3'd6,
        OP_NOT  = 3'd7  // ~a, b ignored
    } alu_op_e;

    // branch style condition codes, signed compare of a against b
    typedef enum logic [2:0] {
        COND_EQ     = 3'd0,
        COND_NE     = 3'd1,
        COND_LT     = 3'd2,
        COND_GE     = 3'd3,
        COND_GT     = 3'd4,
        COND_LE     = 3'd5,
        COND_ALWAYS = 3'd6, // unconditional
        COND_NEVER  = 3'd7
    } cond_e;

endpackage : alu_ops_pkg

// File: source/exec_types_pkg.sv
package exec_types_pkg;

    localparam int DATA_W = 32; // operand and result width
    localparam int TAG_W  = 4;  // command tag, echoed in the response

    // command as it sits in the queue
    typedef struct packed {
        alu_ops_pkg::alu_op_e      op;
        alu_ops_pkg::cond_e        cond;
        logic signed [DATA_W-1:0]  a;
        logic signed [DATA_W-1:0]  b;
        logic [TAG_W-1:0]          tag;
    } exec_cmd_t;

    // status from the alu
    typedef struct packed {
        logic overflow; // signed, add and sub only
        logic negative;
        logic zero;
    } alu_flags_t;

    // compare side
    typedef struct packed {
        logic equal;
        logic greater;
        logic less;
        logic taken; // condition code outcome
    } cmp_flags_t;

    // one response per command, in command order
    typedef struct packed {
        logic signed [DATA_W-1:0] result;
        alu_flags_t               alu_flags;
        cmp_flags_t               cmp_flags;
        logic [TAG_W-1:0]         tag;
    } exec_resp_t;

endpackage : exec_types_pkg

// File: source/cmd_queue.sv
module cmd_queue #(
    parameter int CMD_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      cmd_valid,  // upstream only sends with a credit
    input  exec_types_pkg::exec_cmd_t cmd,
    input  logic                      pop,
    output logic                      head_valid,
    output exec_types_pkg::exec_cmd_t head,
    output logic                      cmd_credit  // one pulse per freed entry
);
    import exec_types_pkg::*;

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    exec_cmd_t        mem [CMD_DEPTH]; // payload storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;           // occupancy

    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];   // read side is combinational

    // payload write on each accepted command
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end else begin
            if (cmd_valid) begin
                // wrap by compare, depth need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({cmd_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or push and pop together
            endcase
            cmd_credit <= pop; // credit back the cycle after the pop edge
        end
    end

endmodule : cmd_queue

// File: source/alu.sv
module alu (
    input  alu_ops_pkg::alu_op_e                    op,
    input  logic signed [exec_types_pkg::DATA_W-1:0] a,
    input  logic signed [exec_types_pkg::DATA_W-1:0] b,
    output logic signed [exec_types_pkg::DATA_W-1:0] result,
    output exec_types_pkg::alu_flags_t               flags
);
    import alu_ops_pkg::*;
    import exec_types_pkg::*;

    logic signed [DATA_W-1:0] res_add;
    logic signed [DATA_W-1:0] res_sub;
    logic [DATA_W-1:0]        shamt;    // full b, 32 and up shifts everything out
    logic                     ovf_add;
    logic                     ovf_sub;

    assign res_add = a + b;
    assign res_sub = a - b;
    assign shamt   = $unsigned(b);

    // same sign in, other sign out
    assign ovf_add = (a[DATA_W-1] == b[DATA_W-1]) && (res_add[DATA_W-1] != a[DATA_W-1]);
    // signs differ and result left the sign of a
    assign ovf_sub = (a[DATA_W-1] != b[DATA_W-1]) && (res_sub[DATA_W-1] != a[DATA_W-1]);

    always_comb begin
        case (op)
            OP_ADD:  result = res_add;
            OP_SUB:  result = res_sub;
            OP_SHL:  result = a << shamt;
            OP_SHR:  result = $signed($unsigned(a) >> shamt); // logical, zero fill
            OP_LOAD: result = a;
            OP_AND:  result = a & b;
            OP_XOR:  result = a ^ b;
            OP_NOT:  result = ~a;
            default: result = '0;
        endcase
    end

    always_comb begin
        case (op)
            OP_ADD:  flags.overflow = ovf_add;
            OP_SUB:  flags.overflow = ovf_sub;
            default: flags.overflow = 1'b0; // logic and shifts never overflow
        endcase
    end

    assign flags.negative = result[DATA_W-1];
    assign flags.zero     = (result == '0);

endmodule : alu

// File: source/cond_eval.sv
module cond_eval (
    input  alu_ops_pkg::cond_e                      cond,
    input  logic signed [exec_types_pkg::DATA_W-1:0] a,
    input  logic signed [exec_types_pkg::DATA_W-1:0] b,
    output exec_types_pkg::cmp_flags_t               flags
);
    import alu_ops_pkg::*;

    logic eq;
    logic gt;
    logic lt;
    logic taken;

    // both operands signed, so these are signed compares
    assign eq = (a == b);
    assign gt = (a > b);
    assign lt = (a < b);

    always_comb begin
        case (cond)
            COND_EQ:     taken = eq;
            COND_NE:     taken = !eq;
            COND_LT:     taken = lt;
            COND_GE:     taken = gt | eq;
            COND_GT:     taken = gt;
            COND_LE:     taken = lt | eq;
            COND_ALWAYS: taken = 1'b1;
            COND_NEVER:  taken = 1'b0;
            default:     taken = 1'b0;
        endcase
    end

    assign flags.equal   = eq;
    assign flags.greater = gt;
    assign flags.less    = lt;
    assign flags.taken   = taken;

endmodule : cond_eval

// File: source/result_merge.sv
module result_merge #(
    parameter int RESP_CREDITS = 2
) (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     head_valid,
    input  logic [exec_types_pkg::TAG_W-1:0]         tag,
    input  logic signed [exec_types_pkg::DATA_W-1:0] alu_result,
    input  exec_types_pkg::alu_flags_t               alu_flags,
    input  exec_types_pkg::cmp_flags_t               cmp_flags,
    input  logic                                     resp_credit, // downstream frees one slot
    output logic                                     pop,
    output logic                                     resp_valid,
    output exec_types_pkg::exec_resp_t               resp
);
    import exec_types_pkg::*;

    localparam int CNT_W = $clog2(RESP_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt; // downstream slots we may still fill
    exec_resp_t       resp_d;

    // send whenever there is work and a slot downstream
    assign pop = head_valid && (credit_cnt != '0);

    // join the two parallel results
    always_comb begin
        resp_d.result    = alu_result;
        resp_d.alu_flags = alu_flags;
        resp_d.cmp_flags = cmp_flags;
        resp_d.tag       = tag;
    end

    // response payload, loaded only on pop
    always_ff @(posedge clk) begin
        if (pop) begin
            resp <= resp_d;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
            credit_cnt <= CNT_W'(RESP_CREDITS);
        end else begin
            resp_valid <= pop; // single cycle strobe
            case ({pop, resp_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1; // spent on send
                2'b01:   credit_cnt <= credit_cnt + 1'b1; // returned
                default: credit_cnt <= credit_cnt;        // none, or both cancel
            endcase
        end
    end

endmodule : result_merge

// File: source/exec_unit.sv
module exec_unit #(
    parameter int CMD_DEPTH    = 4,
    parameter int RESP_CREDITS = 2
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       cmd_valid,
    input  exec_types_pkg::exec_cmd_t  cmd,
    output logic                       cmd_credit,
    output logic                       resp_valid,
    output exec_types_pkg::exec_resp_t resp,
    input  logic                       resp_credit
);
    import exec_types_pkg::*;

    logic                     head_valid;
    exec_cmd_t                head;        // queue head, read by both units
    logic                     pop;
    logic signed [DATA_W-1:0] alu_result;
    alu_flags_t               alu_flags;
    cmp_flags_t               cmp_flags;

    cmd_queue #(
        .CMD_DEPTH (CMD_DEPTH)
    ) u_cmd_queue (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .pop        (pop),
        .head_valid (head_valid),
        .head       (head),
        .cmd_credit (cmd_credit)
    );

    // result path
    alu u_alu (
        .op     (head.op),
        .a      (head.a),
        .b      (head.b),
        .result (alu_result),
        .flags  (alu_flags)
    );

    // compare path, side by side with the alu
    cond_eval u_cond_eval (
        .cond  (head.cond),
        .a     (head.a),
        .b     (head.b),
        .flags (cmp_flags)
    );

    result_merge #(
        .RESP_CREDITS (RESP_CREDITS)
    ) u_result_merge (
        .clk         (clk),
        .arst_n      (arst_n),
        .head_valid  (head_valid),
        .tag         (head.tag),
        .alu_result  (alu_result),
        .alu_flags   (alu_flags),
        .cmp_flags   (cmp_flags),
        .resp_credit (resp_credit),
        .pop         (pop),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

endmodule : exec_unit

// File: tb/exec_unit_assertions.sv
module exec_unit_assertions #(
    parameter int CMD_DEPTH    = 4,
    parameter int RESP_CREDITS = 2
) (
    input logic                                  clk,
    input logic                                  arst_n,
    input logic                                  cmd_credit,
    input logic                                  resp_valid,
    input logic                                  resp_credit,
    input logic [$clog2(CMD_DEPTH + 1)-1:0]      q_count,    // queue occupancy
    input logic [$clog2(RESP_CREDITS + 1)-1:0]   credit_cnt  // downstream credits held
);

    int port_credits; // credits held, counted from the port traffic

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            port_credits <= RESP_CREDITS;
        end else begin
            port_credits <= port_credits - int'(resp_valid) + int'(resp_credit);
        end
    end

    occupancy_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        q_count <= CMD_DEPTH)
        else $error("command queue holds more entries than its depth");

    credits_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        credit_cnt <= RESP_CREDITS)
        else $error("downstream credit count above its start value");

    // a send needs a credit in hand
    send_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid |-> port_credits > 0)
        else $error("response sent with no downstream credit");

    no_credit_in_reset: assert property (@(posedge clk) !arst_n |-> !cmd_credit)
        else $error("cmd_credit high during reset");

endmodule : exec_unit_assertions

bind exec_unit exec_unit_assertions #(
    .CMD_DEPTH    (CMD_DEPTH),
    .RESP_CREDITS (RESP_CREDITS)
) u_exec_unit_assertions (
    .clk         (clk),
    .arst_n      (arst_n),
    .cmd_credit  (cmd_credit),
    .resp_valid  (resp_valid),
    .resp_credit (resp_credit),
    .q_count     (u_cmd_queue.count),
    .credit_cnt  (u_result_merge.credit_cnt)
);

// File: tb/tb_exec_unit.sv
module tb_exec_unit;
    import alu_ops_pkg::*;
    import exec_types_pkg::*;

    localparam int CMD_DEPTH    = 4;
    localparam int RESP_CREDITS = 2;
    localparam int N_RANDOM     = 300;
    localparam int N_CMDS       = 9 + 14 + 24 + 20 + N_RANDOM; // all tests together

    logic       clk = 1'b0;
    logic       arst_n;
    logic       cmd_valid;
    exec_cmd_t  cmd;
    logic       cmd_credit;
    logic       resp_valid;
    exec_resp_t resp;
    logic       resp_credit;

    int         seed = 32'h448a_7df9;
    int         up_credits = CMD_DEPTH; // driver side view of the queue
    int         pend_credits = 0;       // responses not yet credited back
    int         credit_mode = 0;        // 0 prompt, 1 withhold, 2 random
    int         errors = 0;
    int         n_checked = 0;
    logic [TAG_W-1:0] next_tag = '0;
    exec_resp_t exp_q[$];

    exec_unit #(.CMD_DEPTH(CMD_DEPTH), .RESP_CREDITS(RESP_CREDITS)) u_exec_unit (
        .clk(clk), .arst_n(arst_n), .cmd_valid(cmd_valid), .cmd(cmd),
        .cmd_credit(cmd_credit), .resp_valid(resp_valid), .resp(resp),
        .resp_credit(resp_credit)
    );

    always #10 clk = ~clk;

    // expected response, worked out from the alu and compare rules
    function automatic exec_resp_t ref_exec(input exec_cmd_t c);
        exec_resp_t r;
        logic [DATA_W:0] wide;
        logic [DATA_W-1:0] ua;
        longint sa;
        longint sb;
        r = '0;
        ua = c.a;
        sa = c.a;
        sb = c.b;
        case (c.op)
            OP_ADD: begin
                wide = {c.a[DATA_W-1], c.a} + {c.b[DATA_W-1], c.b};
                r.result = wide[DATA_W-1:0];
                r.alu_flags.overflow = wide[DATA_W] ^ wide[DATA_W-1]; // 33 bit sign check
            end
            OP_SUB: begin
                wide = {c.a[DATA_W-1], c.a} - {c.b[DATA_W-1], c.b};
                r.result = wide[DATA_W-1:0];
                r.alu_flags.overflow = wide[DATA_W] ^ wide[DATA_W-1];
            end
            OP_SHL:  r.result = ($unsigned(c.b) > 31) ? '0 : ua << c.b[4:0];
            OP_SHR:  r.result = ($unsigned(c.b) > 31) ? '0 : ua >> c.b[4:0];
            OP_LOAD: r.result = c.a;
            OP_AND:  r.result = c.a & c.b;
            OP_XOR:  r.result = c.a ^ c.b;
            default: r.result = ~c.a;
        endcase
        r.alu_flags.negative = r.result[DATA_W-1];
        r.alu_flags.zero = (r.result == 0);
        r.cmp_flags.equal = (sa == sb);
        r.cmp_flags.greater = (sa > sb);
        r.cmp_flags.less = (sa < sb);
        case (c.cond)
            COND_EQ:     r.cmp_flags.taken = (sa == sb);
            COND_NE:     r.cmp_flags.taken = (sa != sb);
            COND_LT:     r.cmp_flags.taken = (sa < sb);
            COND_GE:     r.cmp_flags.taken = (sa >= sb);
            COND_GT:     r.cmp_flags.taken = (sa > sb);
            COND_LE:     r.cmp_flags.taken = (sa <= sb);
            COND_ALWAYS: r.cmp_flags.taken = 1'b1;
            default:     r.cmp_flags.taken = 1'b0;
        endcase
        r.tag = c.tag;
        return r;
    endfunction

    // upstream credits, spent on each valid cycle
    always @(posedge clk) begin
        if (arst_n) up_credits <= up_credits + int'(cmd_credit) - int'(cmd_valid);
    end

    // downstream side, returns credits by mode
    always begin
        logic give;
        @(posedge clk);
        if (resp_valid) pend_credits++;
        // decided on the edge itself
        give = (pend_credits > 0) &&
               (credit_mode == 0 || (credit_mode == 2 && ($random(seed) & 3) == 0));
        #1;
        resp_credit = give;
        if (give) pend_credits--;
    end

    // scoreboard
    always @(posedge clk) begin
        exec_resp_t e;
        if (arst_n && resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("response with tag %h arrived with nothing expected", resp.tag);
                errors++;
            end else begin
                e = exp_q.pop_front();
                n_checked++;
                assert (resp.tag == e.tag) else begin
                    $display("Mismatch tag: got %h expected %h", resp.tag, e.tag);
                    errors++;
                end
                assert (resp.result == e.result) else begin
                    $display("Mismatch result: got %h expected %h", resp.result, e.result);
                    errors++;
                end
                assert (resp.alu_flags == e.alu_flags) else begin
                    $display("Mismatch alu_flags: got %h expected %h", resp.alu_flags, e.alu_flags);
                    errors++;
                end
                assert (resp.cmp_flags == e.cmp_flags) else begin
                    $display("Mismatch cmp_flags: got %h expected %h", resp.cmp_flags, e.cmp_flags);
                    errors++;
                end
            end
        end
    end

    // waits for a credit, then one valid cycle
    task automatic send(input alu_op_e op, input cond_e cond, input int a, input int b);
        exec_cmd_t c;
        c = '{op: op, cond: cond, a: a, b: b, tag: next_tag};
        next_tag++;
        while (up_credits == 0) begin
            @(posedge clk); #1;
        end
        cmd_valid = 1'b1;
        cmd = c;
        exp_q.push_back(ref_exec(c));
        @(posedge clk); #1;
        cmd_valid = 1'b0;
    endtask

    task automatic finish_test(input string name, input int err_start);
        while (exp_q.size() != 0) begin
            @(posedge clk); #1;
        end
        $display("%s: done, %0d errors", name, errors - err_start);
    endtask

    initial begin
        int e0;
        int gap;
        arst_n = 1'b0;
        cmd_valid = 1'b0;
        cmd = '0;
        resp_credit = 1'b0;
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
        e0 = errors; // signed limits
        send(OP_ADD, COND_EQ, 32'h7fff_ffff, 1);
        send(OP_ADD, COND_EQ, 32'h8000_0000, -1);
        send(OP_ADD, COND_EQ, 32'h7fff_ffff, 32'h8000_0000);
        send(OP_ADD, COND_EQ, -1, 1);
        send(OP_ADD, COND_EQ, 32'h8000_0000, 32'h8000_0000);
        send(OP_SUB, COND_EQ, 32'h8000_0000, 1);
        send(OP_SUB, COND_EQ, 32'h7fff_ffff, -1);
        send(OP_SUB, COND_EQ, 0, 32'h8000_0000);
        send(OP_SUB, COND_EQ, 5, 5);
        finish_test("add_sub_limits", e0);
        e0 = errors; // shift amounts and logic ops
        send(OP_SHL, COND_NE, 32'h8000_0001, 0);
        send(OP_SHL, COND_NE, 32'h0000_0003, 31);
        send(OP_SHL, COND_NE, 32'hffff_ffff, 32);
        send(OP_SHL, COND_NE, 32'h1234_5678, 100);
        send(OP_SHR, COND_NE, 32'h8000_0000, 0);
        send(OP_SHR, COND_NE, 32'h8000_0000, 31);
        send(OP_SHR, COND_NE, 32'hffff_ffff, 32);
        send(OP_SHR, COND_NE, 32'hffff_ffff, -1);
        send(OP_LOAD, COND_NE, 32'h8000_0000, 7);
        send(OP_LOAD, COND_NE, 0, 7);
        send(OP_AND, COND_NE, 32'hf0f0_f0f0, 32'h0ff0_0ff0);
        send(OP_XOR, COND_NE, 32'hdead_beef, 32'hdead_beef);
        send(OP_NOT, COND_NE, 0, 3);
        send(OP_NOT, COND_NE, -1, 3);
        finish_test("shift_logic", e0);
        e0 = errors; // every condition code over lt, eq, gt
        for (int cc = 0; cc < 8; cc++) begin
            send(OP_SUB, cond_e'(cc), -5, 3);
            send(OP_SUB, cond_e'(cc), 7, 7);
            send(OP_SUB, cond_e'(cc), 3, -5);
        end
        finish_test("cond_codes", e0);
        e0 = errors; // downstream holds its credits
        credit_mode = 1;
        fork
            for (int i = 0; i < 20; i++) send(alu_op_e'(i % 8), COND_LT, i, 10 - i);
            begin
                repeat (80) @(posedge clk);
                #1;
                assert (up_credits == 0) else begin
                    $display("driver still held credits while downstream was blocked");
                    errors++;
                end
                credit_mode = 0;
            end
        join
        finish_test("back_pressure", e0);
        e0 = errors; // random stream
        credit_mode = 2;
        for (int i = 0; i < N_RANDOM; i++) begin
            int a;
            int b;
            a = $random(seed);
            if (($random(seed) & 3) == 0) begin
                b = a;
            end else if ($random(seed) & 1) begin
                b = $random(seed);
            end else begin
                b = $random(seed) & 63; // small, hits the shift amounts
            end
            send(alu_op_e'($random(seed) & 7), cond_e'($random(seed) & 7), a, b);
            gap = $random(seed) & 3;
            repeat (gap) begin
                @(posedge clk); #1;
            end
        end
        credit_mode = 0;
        finish_test("random_stream", e0);
        repeat (4) @(posedge clk);
        #1;
        assert (up_credits == CMD_DEPTH) else begin
            $display("only %0d of %0d upstream credits came back", up_credits, CMD_DEPTH);
            errors++;
        end
        $display("checked %0d responses, %0d errors", n_checked, errors);
        if (errors == 0) $display("TB PASSED");
        else $display("TB FAILED");
        $finish;
    end

    initial begin
        #(N_CMDS * 40 * 20);
        $display("watchdog expired with %0d responses outstanding", exp_q.size());
        $display("TB FAILED");
        $finish;
    end

endmodule : tb_exec_unit

// File: verilog.f
source/alu_ops_pkg.sv
source/exec_types_pkg.sv
source/cmd_queue.sv
source/alu.sv
source/cond_eval.sv
source/result_merge.sv
source/exec_unit.sv
tb/exec_unit_assertions.sv
tb/tb_exec_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_unit
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f verilog.f
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
